// ==== memSys.f ====
rtl/memSysPkg.sv
rtl/cacheWay.sv
rtl/bankedMem.sv
rtl/cacheCtrl.sv
rtl/memSys.sv
bench/memSysChecker.sv
bench/memSysTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -Wno-fatal --top-module memSysTb -f memSys.f \
    && ./obj_dir/VmemSysTb 2>&1 | tee sim.log \
    && ! grep -q "Test failed" sim.log \
    && grep -q "Test passed" sim.log \
    && echo "simulation clean" \
    || { echo "simulation reported errors, see sim.log"; exit 1; }

// ==== bench/memSysTb.sv ====
`timescale 1ns/1ps
// Memory subsystem testbench
// Directed and LFSR-random requests, each predicted by a model of the
// cache tags and a flat shadow memory; the checker does the comparing

module memSysTb
    import memSysPkg::*;
();

    localparam int clkPeriod = 40;
    localparam int resetCycles = 8;
    localparam int totalRequests = 225;
    localparam int cyclesPerRequest = 60;
    localparam int sets = 1 << indexW;

    logic             clk = 1'b0;
    logic             arstN;
    logic [addrW-1:0] Addr;
    logic [addrW-1:0] DataIn;
    logic             Rd;
    logic             Wr;
    logic [addrW-1:0] DataOut;
    logic             Done;
    logic             Stall;
    logic             CacheHit;
    logic             err;

    // Expected result of the open request
    logic [addrW-1:0] expData;
    logic             expHit;
    logic             expErr;
    logic             expRead;

    int checkTotal;
    int failTotal;
    int checksAtStart;
    int failsAtStart;
    int reqCount = 0;
    logic [31:0] lfsr = 32'd74529;

    // Reference model state
    logic [addrW-1:0] shadow [1 << (addrW-1)];     // One entry per 16-bit word
    logic [tagW-1:0]  modelTag [2][sets];
    logic             modelValid [2][sets];
    logic             modelVictim;

    always #(clkPeriod / 2) clk = ~clk;

    memSys #(.memWords(32768)) memSys_inst (
        .clk(clk), .arstN(arstN), .Addr(Addr), .DataIn(DataIn), .Rd(Rd), .Wr(Wr),
        .DataOut(DataOut), .Done(Done), .Stall(Stall), .CacheHit(CacheHit), .err(err)
    );

    memSysChecker resultCheck (
        .clk(clk), .arstN(arstN), .Rd(Rd), .Wr(Wr), .DataOut(DataOut), .Done(Done),
        .Stall(Stall), .CacheHit(CacheHit), .err(err), .expData(expData),
        .expHit(expHit), .expErr(expErr), .expRead(expRead),
        .checks(checkTotal), .fails(failTotal)
    );

    // Galois LFSR, one step per bit
    function automatic logic lfsrStep();
        logic outBit;
        outBit = lfsr[0];
        lfsr = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return outBit;
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsrStep()};
        end
        return v;
    endfunction

    // Expected outcome of one request; updates the model as the cache would
    function automatic void predict(input logic isWr, input logic [addrW-1:0] addr,
            input logic [addrW-1:0] data, output logic [addrW-1:0] expD,
            output logic expH, output logic expE);
        logic [tagW-1:0]   tag;
        logic [indexW-1:0] idx;
        logic              way;
        tag = addr[15:11];
        idx = addr[10:3];
        expD = '0;
        expH = 1'b0;
        expE = addr[0];
        if (!addr[0]) begin
            modelVictim = ~modelVictim;             // Every served request flips it
            if (modelValid[0][idx] && modelTag[0][idx] == tag) begin
                expH = 1'b1;
            end else if (modelValid[1][idx] && modelTag[1][idx] == tag) begin
                expH = 1'b1;
            end else begin
                way = !modelValid[0][idx] ? 1'b0 : !modelValid[1][idx] ? 1'b1 : modelVictim;
                modelTag[way][idx] = tag;
                modelValid[way][idx] = 1'b1;
            end
            if (isWr) begin
                shadow[addr[15:1]] = data;
            end else begin
                expD = shadow[addr[15:1]];
            end
        end
    endfunction

    task automatic issueRequest(input logic isWr, input logic [addrW-1:0] addr,
            input logic [addrW-1:0] data);
        logic [addrW-1:0] expD;
        logic             expH;
        logic             expE;
        predict(isWr, addr, data, expD, expH, expE);
        @(posedge clk);
        Addr <= addr;
        DataIn <= data;
        Rd <= ~isWr;
        Wr <= isWr;
        expData <= expD;
        expHit <= expH;
        expErr <= expE;
        expRead <= ~isWr;
        @(posedge clk);                 // Taken by the idle controller here
        Rd <= 1'b0;
        Wr <= 1'b0;
        do begin
            @(negedge clk);
        end while (!(Done || err));
        reqCount++;
    endtask

    task automatic beginTest();
        checksAtStart = checkTotal;
        failsAtStart = failTotal;
    endtask

    task automatic reportTest(input string name);
        @(posedge clk);                 // Checker counts settle first
        $display("%s: %0d checks, %0d errors", name, checkTotal - checksAtStart,
            failTotal - failsAtStart);
    endtask

    // Watchdog
    initial begin
        repeat (resetCycles + totalRequests * cyclesPerRequest) @(posedge clk);
        $display("Watchdog expired after %0d requests, the DUT stopped answering", reqCount);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic             wr;
        logic [1:0]       tag;
        logic [2:0]       idx;
        logic [1:0]       word;
        logic [addrW-1:0] data;
        arstN = 1'b0;
        Rd = 1'b0;
        Wr = 1'b0;
        Addr = '0;
        DataIn = '0;
        expData = '0;
        expHit = 1'b0;
        expErr = 1'b0;
        expRead = 1'b0;
        modelVictim = 1'b0;
        for (int a = 0; a < (1 << (addrW-1)); a++) begin
            shadow[a] = '0;
        end
        for (int s = 0; s < sets; s++) begin
            modelValid[0][s] = 1'b0;
            modelValid[1][s] = 1'b0;
            modelTag[0][s] = '0;
            modelTag[1][s] = '0;
        end
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;

        beginTest();
        issueRequest(1'b0, 16'h0040, '0);
        issueRequest(1'b0, 16'h0040, '0);           // Same word again, two-cycle hit
        reportTest("test 1 read after reset, then hit");

        beginTest();
        issueRequest(1'b1, 16'h0104, 16'hA5C3);
        issueRequest(1'b1, 16'h0100, 16'h3C1E);
        for (int w = 0; w < 4; w++) begin
            issueRequest(1'b0, 16'h0100 + 16'(2 * w), '0);
        end
        reportTest("test 2 write then read of one line");

        // Index 5, tags 0, 1 and 2
        beginTest();
        issueRequest(1'b0, 16'h0028, '0);
        issueRequest(1'b0, 16'h0828, '0);
        issueRequest(1'b0, 16'h1028, '0);
        issueRequest(1'b0, 16'h1028, '0);
        issueRequest(1'b0, 16'h0028, '0);
        issueRequest(1'b0, 16'h0828, '0);
        reportTest("test 3 eviction order");

        // Two dirty lines at index 9, pushed out by two clean ones
        beginTest();
        issueRequest(1'b1, 16'h004A, 16'hD00D);
        issueRequest(1'b1, 16'h084C, 16'hE00E);
        issueRequest(1'b0, 16'h1048, '0);
        issueRequest(1'b0, 16'h1848, '0);
        issueRequest(1'b0, 16'h004A, '0);
        issueRequest(1'b0, 16'h084C, '0);
        reportTest("test 4 dirty writeback");

        beginTest();
        issueRequest(1'b0, 16'h0051, '0);
        issueRequest(1'b1, 16'h0213, 16'hBEEF);
        issueRequest(1'b0, 16'h0212, '0);
        issueRequest(1'b1, 16'h0212, 16'h1234);
        issueRequest(1'b0, 16'h0212, '0);
        reportTest("test 5 odd address");

        // Four tags over eight sets keep both ways busy
        beginTest();
        for (int n = 0; n < 200; n++) begin
            wr = 1'(randBits(1));
            tag = 2'(randBits(2));
            idx = 3'(randBits(3));
            word = 2'(randBits(2));
            data = randBits(16);
            issueRequest(wr, {3'b000, tag, 5'b00010, idx, word, 1'b0}, data);
        end
        reportTest("test 6 random reads and writes");

        @(posedge clk);
        $display("requests %0d, checks %0d, errors %0d", reqCount, checkTotal, failTotal);
        if (failTotal == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== bench/memSysChecker.sv ====
`timescale 1ns/1ps
// Result checker for the memory subsystem
// Watches the DUT ports on the falling edge, tracks the open request
// and compares each result and the Stall level with the expected values

module memSysChecker
    import memSysPkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  logic             Rd,
    input  logic             Wr,
    input  logic [addrW-1:0] DataOut,
    input  logic             Done,
    input  logic             Stall,
    input  logic             CacheHit,
    input  logic             err,
    input  logic [addrW-1:0] expData,
    input  logic             expHit,
    input  logic             expErr,
    input  logic             expRead,
    output int               checks,
    output int               fails
);

    int   checkCount = 0;
    int   failCount = 0;
    logic pending = 1'b0;       // Request accepted, result not yet seen
    int   waited = 0;           // Cycles since acceptance

    assign checks = checkCount;
    assign fails = failCount;

    task automatic compareValue(input string name, input logic [addrW-1:0] expected,
            input logic [addrW-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            failCount++;
            $display("[FAIL] %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic reportProblem(input string what);
        checkCount++;
        failCount++;
        $display("Error at %0t: %s", $time, what);
    endtask

    always @(negedge clk) begin
        if (!arstN) begin
            if (Done || CacheHit || err) begin
                reportProblem("result strobe active during reset");
            end
        end else begin
            // Stall drops only in the Done cycle or an idle cycle without a request
            compareValue("Stall", pending ? 16'(!Done) : 16'(Rd || Wr), 16'(Stall));
            if (pending) begin
                waited++;
            end
            if (Done || err) begin
                if (!pending) begin
                    reportProblem("Done or err raised without an open request");
                end else if (Done && err) begin
                    reportProblem("Done and err raised in the same cycle");
                end else begin
                    compareValue("err", 16'(expErr), 16'(err));
                    if (Done) begin
                        compareValue("CacheHit", 16'(expHit), 16'(CacheHit));
                        if (expRead) begin
                            compareValue("DataOut", expData, DataOut);
                        end
                        if (CacheHit && waited != 1) begin
                            reportProblem($sformatf("hit completed %0d cycles after acceptance",
                                waited));
                        end
                    end
                end
                pending = 1'b0;
            end else if (!pending && (Rd || Wr)) begin
                pending = 1'b1;             // Accepting cycle
                waited = 0;
            end
        end
    end

endmodule

// ==== rtl/memSys.sv ====
`timescale 1ns/1ps
// Memory subsystem top level
// Two-way write-back data cache in front of four-bank main memory

module memSys
    import memSysPkg::*;
#(
    parameter int memWords = 32768
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic [addrW-1:0] Addr,
    input  logic [addrW-1:0] DataIn,
    input  logic             Rd,
    input  logic             Wr,
    output logic [addrW-1:0] DataOut,
    output logic             Done,
    output logic             Stall,
    output logic             CacheHit,
    output logic             err
);

    // Shared way controls
    logic               en0;
    logic               en1;
    logic               comp;
    logic               write;
    logic               validIn;
    logic [tagW-1:0]    tagIn;
    logic [indexW-1:0]  index;
    logic [offsetW-1:0] offset;
    logic [addrW-1:0]   cacheDataIn;

    // Per-way lookup results
    logic [tagW-1:0]    tagOut0;
    logic [tagW-1:0]    tagOut1;
    logic [addrW-1:0]   wayData0;
    logic [addrW-1:0]   wayData1;
    logic               hit0;
    logic               hit1;
    logic               dirty0;
    logic               dirty1;
    logic               valid0;
    logic               valid1;

    logic [addrW-1:0]   memAddr;
    logic [addrW-1:0]   memDataIn;
    logic [addrW-1:0]   memDataOut;
    logic               memRd;
    logic               memWr;
    logic               memStall;
    logic [3:0]         bankBusy;

    cacheWay way0 (
        .clk(clk), .arstN(arstN), .enable(en0), .comp(comp), .write(write),
        .validIn(validIn), .tagIn(tagIn), .index(index), .offset(offset),
        .dataIn(cacheDataIn), .tagOut(tagOut0), .dataOut(wayData0),
        .hit(hit0), .dirty(dirty0), .valid(valid0)
    );

    cacheWay way1 (
        .clk(clk), .arstN(arstN), .enable(en1), .comp(comp), .write(write),
        .validIn(validIn), .tagIn(tagIn), .index(index), .offset(offset),
        .dataIn(cacheDataIn), .tagOut(tagOut1), .dataOut(wayData1),
        .hit(hit1), .dirty(dirty1), .valid(valid1)
    );

    bankedMem #(.memWords(memWords)) mem (
        .clk(clk), .arstN(arstN), .rd(memRd), .wr(memWr), .addr(memAddr),
        .dataIn(memDataIn), .dataOut(memDataOut), .stall(memStall),
        .bankBusy(bankBusy)
    );

    cacheCtrl ctrl (
        .clk(clk), .arstN(arstN), .Rd(Rd), .Wr(Wr), .Addr(Addr), .DataIn(DataIn),
        .hit0(hit0), .hit1(hit1), .valid0(valid0), .valid1(valid1),
        .dirty0(dirty0), .dirty1(dirty1), .tagOut0(tagOut0), .tagOut1(tagOut1),
        .wayData0(wayData0), .wayData1(wayData1), .memDataOut(memDataOut),
        .memStall(memStall), .bankBusy(bankBusy),
        .en0(en0), .en1(en1), .comp(comp), .write(write), .validIn(validIn),
        .tagIn(tagIn), .index(index), .offset(offset), .cacheDataIn(cacheDataIn),
        .memAddr(memAddr), .memDataIn(memDataIn), .memRd(memRd), .memWr(memWr),
        .DataOut(DataOut), .Done(Done), .Stall(Stall), .CacheHit(CacheHit),
        .err(err)
    );

endmodule

// ==== rtl/cacheCtrl.sv ====
`timescale 1ns/1ps
// Cache controller FSM
// Captures one request, looks it up in both ways, writes back a dirty
// victim, allocates the missing line and finishes with a second compare.

module cacheCtrl
    import memSysPkg::*;
(
    input  logic               clk,
    input  logic               arstN,
    input  logic               Rd,
    input  logic               Wr,
    input  logic [addrW-1:0]   Addr,
    input  logic [addrW-1:0]   DataIn,
    input  logic               hit0,
    input  logic               hit1,
    input  logic               valid0,
    input  logic               valid1,
    input  logic               dirty0,
    input  logic               dirty1,
    input  logic [tagW-1:0]    tagOut0,
    input  logic [tagW-1:0]    tagOut1,
    input  logic [addrW-1:0]   wayData0,
    input  logic [addrW-1:0]   wayData1,
    input  logic [addrW-1:0]   memDataOut,
    input  logic               memStall,
    input  logic [3:0]         bankBusy,
    output logic               en0,
    output logic               en1,
    output logic               comp,
    output logic               write,
    output logic               validIn,
    output logic [tagW-1:0]    tagIn,
    output logic [indexW-1:0]  index,
    output logic [offsetW-1:0] offset,
    output logic [addrW-1:0]   cacheDataIn,
    output logic [addrW-1:0]   memAddr,
    output logic [addrW-1:0]   memDataIn,
    output logic               memRd,
    output logic               memWr,
    output logic [addrW-1:0]   DataOut,
    output logic               Done,
    output logic               Stall,
    output logic               CacheHit,
    output logic               err
);

    ctrlState_e       state;
    ctrlState_e       nextState;
    logic [addrW-1:0] reqAddr;
    logic [addrW-1:0] reqData;
    logic             reqWr;
    logic             miss;
    logic             selWay;        // Way being replaced
    logic             victimBit;
    logic             request;
    logic             hitAny;
    logic             vicWay;
    logic             vicDirty;
    logic             wbPhase;
    logic             fillPhase;
    logic [1:0]       memWord;
    logic [1:0]       cacheWord;
    logic [tagW-1:0]  victimTag;

    assign request = (state == idle) & (Rd | Wr);
    assign hitAny = hit0 | hit1;                 // Way hits already qualified by valid
    assign vicWay = !valid0 ? 1'b0 : !valid1 ? 1'b1 : victimBit;
    assign vicDirty = vicWay ? (valid1 & dirty1) : (valid0 & dirty0);
    assign victimTag = selWay ? tagOut1 : tagOut0;
    assign wbPhase = state inside {wb0, wb1, wb2, wb3};
    assign fillPhase = state inside {alloc2, alloc3, fill0, fill1};

    always_comb begin
        nextState = state;
        case (state)
            idle:    if (Rd | Wr) nextState = Addr[0] ? errOut : compare;
            compare: nextState = hitAny ? idle : vicDirty ? wb0 : alloc0;
            wb0:     if (!memStall) nextState = wb1;
            wb1:     if (!memStall) nextState = wb2;
            wb2:     if (!memStall) nextState = wb3;
            wb3:     if (!memStall) nextState = wbDrain;
            wbDrain: if (bankBusy == '0) nextState = alloc0;
            alloc0:  nextState = alloc1;
            alloc1:  nextState = alloc2;
            alloc2:  nextState = alloc3;
            alloc3:  nextState = fill0;
            fill0:   nextState = fill1;
            fill1:   nextState = compare;
            default: nextState = idle;              // errOut
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
            reqWr <= 1'b0;
            miss <= 1'b0;
            selWay <= 1'b0;
            victimBit <= 1'b0;
        end else begin
            state <= nextState;
            if (request) begin
                reqWr <= Wr;
                victimBit <= victimBit ^ ~Addr[0];  // Toggle on served requests only
            end
            if (state == idle) begin
                miss <= 1'b0;
            end else if (state == compare && !hitAny) begin
                miss <= 1'b1;
                selWay <= vicWay;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (request) begin
            reqAddr <= Addr;
            reqData <= DataIn;
        end
    end

    // Word order for writeback reads and fill writes
    always_comb begin
        memWord = 2'd0;
        cacheWord = 2'd0;
        case (state)
            wb0, alloc0: memWord = 2'd0;
            wb1, alloc1: memWord = 2'd1;
            wb2, alloc2: memWord = 2'd2;
            wb3, alloc3: memWord = 2'd3;
            default:     memWord = 2'd0;
        endcase
        case (state)
            alloc2:          cacheWord = 2'd0;   // Read from alloc0 returns here
            alloc3:          cacheWord = 2'd1;
            fill0:           cacheWord = 2'd2;
            fill1:           cacheWord = 2'd3;
            wb0, wb1, wb2, wb3: cacheWord = memWord;
            default:         cacheWord = 2'd0;
        endcase
    end

    // Cache side
    assign comp = state == compare;
    assign en0 = comp | ~selWay;
    assign en1 = comp | selWay;
    assign write = fillPhase | (comp & reqWr);
    assign validIn = fillPhase;
    assign tagIn = reqAddr[addrW-1 -: tagW];
    assign index = reqAddr[offsetW +: indexW];
    assign offset = comp ? reqAddr[offsetW-1:0] : {cacheWord, 1'b0};
    assign cacheDataIn = fillPhase ? memDataOut : reqData;

    // Memory side
    assign memAddr = {wbPhase ? victimTag : tagIn, index, memWord, 1'b0};
    assign memDataIn = selWay ? wayData1 : wayData0;
    assign memRd = state inside {alloc0, alloc1, alloc2, alloc3};
    assign memWr = wbPhase & ~memStall;

    // Request results
    assign DataOut = hit1 ? wayData1 : wayData0;
    assign Done = comp & hitAny;
    assign CacheHit = Done & ~miss;
    assign err = state == errOut;
    assign Stall = ((state != idle) & ~Done) | request;

    // The freshly filled line must hit on the closing compare
    fillEndsInDone: assert property (@(posedge clk) disable iff (!arstN)
        (state == fill1) |=> Done)
        else $error("Compare after a fill did not complete the request");

    noStrobeWhileStalled: assert property (@(posedge clk) disable iff (!arstN)
        (memRd || memWr) |-> !memStall)
        else $error("Memory strobe issued to a busy bank");

endmodule

// ==== rtl/bankedMem.sv ====
`timescale 1ns/1ps
// Four-bank main memory
// Banks picked by address bits 2..1, each with its own busy timer.
// Read data comes out memReadLat cycles after the strobe.

module bankedMem
    import memSysPkg::*;
#(
    parameter int memWords = 32768
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             rd,
    input  logic             wr,
    input  logic [addrW-1:0] addr,
    input  logic [addrW-1:0] dataIn,
    output logic [addrW-1:0] dataOut,
    output logic             stall,
    output logic [3:0]       bankBusy
);

    localparam int wordAW = $clog2(memWords);
    localparam int cntW = $clog2(bankBusyCycles + 1);

    logic [addrW-1:0]  mem [memWords];
    logic [addrW-1:0]  readPipe [memReadLat];
    logic [cntW-1:0]   busyCnt [4];
    logic [wordAW-1:0] wordAddr;
    logic [1:0]        bank;
    logic              access;

    assign wordAddr = addr[wordAW:1];
    assign bank = addr[2:1];
    assign stall = busyCnt[bank] != '0;     // Addressed bank still busy
    assign access = (rd | wr) & ~stall;
    assign dataOut = readPipe[memReadLat-1];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            bankBusy[b] = busyCnt[b] != '0;
        end
    end

    // Per-bank busy timers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int b = 0; b < 4; b++) begin
                busyCnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (access && bank == 2'(b)) begin
                    busyCnt[b] <= cntW'(bankBusyCycles);
                end else if (busyCnt[b] != '0) begin
                    busyCnt[b] <= busyCnt[b] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < memWords; i++) begin
                mem[i] <= '0;
            end
        end else if (access && wr) begin
            mem[wordAddr] <= dataIn;
        end
    end

    // Read delay line, one stage per cycle of latency
    always_ff @(posedge clk) begin
        readPipe[0] <= (access && rd) ? mem[wordAddr] : '0;
        for (int s = 1; s < memReadLat; s++) begin
            readPipe[s] <= readPipe[s-1];
        end
    end

    noReadWriteOverlap: assert property (@(posedge clk) disable iff (!arstN)
        !(rd && wr))
        else $error("bankedMem read and write in the same cycle");

endmodule

// ==== rtl/cacheWay.sv ====
`timescale 1ns/1ps
// Single way of the data cache
// Tag, valid, dirty and four data words per set, with a combinational
// tag compare. Compare-mode writes hit only on a tag match.

module cacheWay
    import memSysPkg::*;
(
    input  logic               clk,
    input  logic               arstN,
    input  logic               enable,
    input  logic               comp,
    input  logic               write,
    input  logic               validIn,
    input  logic [tagW-1:0]    tagIn,
    input  logic [indexW-1:0]  index,
    input  logic [offsetW-1:0] offset,
    input  logic [addrW-1:0]   dataIn,
    output logic [tagW-1:0]    tagOut,
    output logic [addrW-1:0]   dataOut,
    output logic               hit,
    output logic               dirty,
    output logic               valid
);

    localparam int sets = 1 << indexW;

    logic [tagW-1:0]  tagMem [sets];
    logic [addrW-1:0] dataMem [sets][wordsPerLine];
    logic [sets-1:0]  validMem;
    logic [sets-1:0]  dirtyMem;
    logic [$clog2(wordsPerLine)-1:0] word;
    logic             compWrite;
    logic             fillWrite;

    assign word = offset[offsetW-1:1];     // Drop the byte bit

    // Lookup for the addressed set
    assign tagOut = tagMem[index];
    assign valid = validMem[index];
    assign dirty = dirtyMem[index];
    assign hit = validMem[index] & (tagMem[index] == tagIn);
    assign dataOut = dataMem[index][word];

    assign compWrite = enable & write & comp & hit;
    assign fillWrite = enable & write & ~comp;

    // Line state bits
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validMem <= '0;
            dirtyMem <= '0;
        end else if (fillWrite) begin
            validMem[index] <= validIn;
            dirtyMem[index] <= 1'b0;           // Fresh line from memory
        end else if (compWrite) begin
            dirtyMem[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fillWrite) begin
            tagMem[index] <= tagIn;
        end
        if (fillWrite || compWrite) begin
            dataMem[index][word] <= dataIn;
        end
    end

    // A compare-mode write has to reach every way
    compWriteEnabled: assert property (@(posedge clk) disable iff (!arstN)
        (write && comp) |-> enable)
        else $error("cacheWay compare write while disabled");

endmodule

// ==== rtl/memSysPkg.sv ====
// Memory subsystem shared definitions
// Address split, line geometry, memory timing and controller states

package memSysPkg;

    localparam int addrW = 16;          // Address and data width
    localparam int tagW = 5;            // Addr[15:11]
    localparam int indexW = 8;          // Addr[10:3]
    localparam int offsetW = 3;         // Byte offset, Addr[2:0]
    localparam int wordsPerLine = 4;

    // Main memory timing
    localparam int memReadLat = 2;
    localparam int bankBusyCycles = 4;

    typedef enum logic [3:0] {
        idle,
        compare,
        wb0,
        wb1,
        wb2,
        wb3,
        wbDrain,    // Wait for all banks to go quiet
        alloc0,
        alloc1,
        alloc2,
        alloc3,
        fill0,      // Last two fill words land here
        fill1,
        errOut
    } ctrlState_e;

endpackage
